// File: files.f
src/gopigo_pkg.sv
src/shadow_cmd_reg.sv
src/cmd_scan_decode.sv
src/frame_build_exec.sv
src/spi_seq_result.sv
src/gopigo_spi_ctrl.sv
verification/gopigo_spi_chk.sv
verification/tb_gopigo_spi_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the command bridge testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f files.f \
  --top-module tb_gopigo_spi_ctrl -o sim_gopigo

out="$(./obj_dir/sim_gopigo)"
echo "$out"

if echo "$out" | grep -q "TB PASSED"; then
  exit 0
else
  exit 1
fi

// File: src/cmd_scan_decode.sv
//##########################################################
// command scan decode
// walks the channels in fixed order and flags the first
// one whose input differs from its shadow copy
//##########################################################
`timescale 1ns/1ps
`default_nettype none

module cmd_scan_decode (
  input  wire                  rst,          // clock
  input  wire                  clk,          // async reset, active high
  input  wire                  scan_en_i,    // sequencer is idle
  input  wire                  load_i,       // capture pulse from sequencer
  input  wire gopigo_pkg::pwm_t pwm_left_i,
  input  wire gopigo_pkg::pwm_t pwm_rght_i,
  input  wire gopigo_pkg::dps_t dps_limit_i,
  input  wire gopigo_pkg::rgb_t eye_left_i,
  input  wire gopigo_pkg::rgb_t eye_rght_i,
  output logic                 cmd_valid_o,  // channel under scan has changed
  output gopigo_pkg::cmd_chan_e cmd_sel_o    // channel under scan
);

  gopigo_pkg::cmd_chan_e          scan_idx_q;
  logic [gopigo_pkg::NUM_CHAN-1:0] chan_chg;  // change flag per channel
  logic                           chg_sel;   // flag of the scanned channel

  // one shadow register per channel, load only reaches the selected one
  shadow_cmd_reg #(.payload_t(gopigo_pkg::pwm_t)) u_shadow_pwm_left (
    .rst(rst), .clk(clk),
    .load_i(load_i && (scan_idx_q == gopigo_pkg::CH_PWM_LEFT)),
    .value_i(pwm_left_i), .changed_o(chan_chg[0]));

  shadow_cmd_reg #(.payload_t(gopigo_pkg::pwm_t)) u_shadow_pwm_rght (
    .rst(rst), .clk(clk),
    .load_i(load_i && (scan_idx_q == gopigo_pkg::CH_PWM_RGHT)),
    .value_i(pwm_rght_i), .changed_o(chan_chg[1]));

  shadow_cmd_reg #(.payload_t(gopigo_pkg::dps_t)) u_shadow_dps_limit (
    .rst(rst), .clk(clk),
    .load_i(load_i && (scan_idx_q == gopigo_pkg::CH_DPS_LIMIT)),
    .value_i(dps_limit_i), .changed_o(chan_chg[2]));

  shadow_cmd_reg #(.payload_t(gopigo_pkg::rgb_t)) u_shadow_eye_left (
    .rst(rst), .clk(clk),
    .load_i(load_i && (scan_idx_q == gopigo_pkg::CH_EYE_LEFT)),
    .value_i(eye_left_i), .changed_o(chan_chg[3]));

  shadow_cmd_reg #(.payload_t(gopigo_pkg::rgb_t)) u_shadow_eye_rght (
    .rst(rst), .clk(clk),
    .load_i(load_i && (scan_idx_q == gopigo_pkg::CH_EYE_RGHT)),
    .value_i(eye_rght_i), .changed_o(chan_chg[4]));

  // unused codes never report a change
  always_comb begin
    case (scan_idx_q)
      gopigo_pkg::CH_PWM_LEFT:  chg_sel = chan_chg[0];
      gopigo_pkg::CH_PWM_RGHT:  chg_sel = chan_chg[1];
      gopigo_pkg::CH_DPS_LIMIT: chg_sel = chan_chg[2];
      gopigo_pkg::CH_EYE_LEFT:  chg_sel = chan_chg[3];
      gopigo_pkg::CH_EYE_RGHT:  chg_sel = chan_chg[4];
      default:                  chg_sel = 1'b0;
    endcase
  end

  // hold on a change, otherwise step to the next channel and wrap
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      scan_idx_q <= gopigo_pkg::CH_PWM_LEFT;
    end else if (scan_en_i && !chg_sel) begin
      if (scan_idx_q == gopigo_pkg::cmd_chan_e'(gopigo_pkg::NUM_CHAN - 1)) begin
        scan_idx_q <= gopigo_pkg::CH_PWM_LEFT;
      end else begin
        scan_idx_q <= gopigo_pkg::cmd_chan_e'(scan_idx_q + 3'd1);
      end
    end
  end

  assign cmd_valid_o = chg_sel;
  assign cmd_sel_o   = scan_idx_q;

endmodule

`default_nettype wire

// File: src/frame_build_exec.sv
//##########################################################
// frame build execute
// encodes the selected command into an spi frame on load
// and hands out its bytes by index
//##########################################################
`timescale 1ns/1ps
`default_nettype none

module frame_build_exec (
  input  wire                       rst,          // clock
  input  wire                       clk,          // async reset, active high
  input  wire                       load_i,       // latch a new frame
  input  wire gopigo_pkg::cmd_chan_e cmd_sel_i,   // channel to encode
  input  wire gopigo_pkg::pwm_t      pwm_left_i,
  input  wire gopigo_pkg::pwm_t      pwm_rght_i,
  input  wire gopigo_pkg::dps_t      dps_limit_i,
  input  wire gopigo_pkg::rgb_t      eye_left_i,
  input  wire gopigo_pkg::rgb_t      eye_rght_i,
  input  wire gopigo_pkg::frame_idx_t byte_idx_i, // byte asked for by the sequencer
  output gopigo_pkg::frame_idx_t     last_idx_o,  // index of the final byte
  output gopigo_pkg::byte_t          byte_o       // byte at byte_idx_i
);

  gopigo_pkg::byte_t      frame_d [gopigo_pkg::FRAME_BYTES];  // encoder output
  gopigo_pkg::byte_t      frame_q [gopigo_pkg::FRAME_BYTES];  // latched frame
  gopigo_pkg::frame_idx_t last_d;
  gopigo_pkg::frame_idx_t last_q;

  // frame encoder, unused tail bytes stay zero
  always_comb begin
    frame_d    = '{default: '0};
    frame_d[0] = gopigo_pkg::SPI_ADDR;
    last_d     = gopigo_pkg::frame_idx_t'(3);  // short pwm frame by default
    case (cmd_sel_i)
      gopigo_pkg::CH_PWM_LEFT: begin
        frame_d[1] = gopigo_pkg::MSG_SET_MOTOR_PWM;
        frame_d[2] = gopigo_pkg::TGT_MOTOR_LEFT;
        frame_d[3] = pwm_left_i;                  // sign bit goes out as is
      end
      gopigo_pkg::CH_PWM_RGHT: begin
        frame_d[1] = gopigo_pkg::MSG_SET_MOTOR_PWM;
        frame_d[2] = gopigo_pkg::TGT_MOTOR_RGHT;
        frame_d[3] = pwm_rght_i;
      end
      gopigo_pkg::CH_DPS_LIMIT: begin
        frame_d[1] = gopigo_pkg::MSG_SET_MOTOR_LIMITS;
        frame_d[2] = gopigo_pkg::TGT_MOTOR_BOTH;
        frame_d[3] = 8'h00;                       // power limit 0, limit by dps
        frame_d[4] = dps_limit_i[15:8];           // high byte first
        frame_d[5] = dps_limit_i[7:0];
        last_d     = gopigo_pkg::frame_idx_t'(5);
      end
      gopigo_pkg::CH_EYE_LEFT: begin
        frame_d[1] = gopigo_pkg::MSG_SET_LED;
        frame_d[2] = gopigo_pkg::TGT_EYE_LEFT;
        frame_d[3] = eye_left_i[23:16];           // red
        frame_d[4] = eye_left_i[15:8];            // green
        frame_d[5] = eye_left_i[7:0];             // blue
        last_d     = gopigo_pkg::frame_idx_t'(5);
      end
      gopigo_pkg::CH_EYE_RGHT: begin
        frame_d[1] = gopigo_pkg::MSG_SET_LED;
        frame_d[2] = gopigo_pkg::TGT_EYE_RGHT;
        frame_d[3] = eye_rght_i[23:16];
        frame_d[4] = eye_rght_i[15:8];
        frame_d[5] = eye_rght_i[7:0];
        last_d     = gopigo_pkg::frame_idx_t'(5);
      end
      default: ;                                  // codes 5 to 7 are never scanned
    endcase
  end

  always_ff @(posedge rst) begin
    if (load_i) begin
      frame_q <= frame_d;
    end
  end

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      last_q <= '0;
    end else if (load_i) begin
      last_q <= last_d;
    end
  end

  assign last_idx_o = last_q;
  // indexes past the frame read as zero
  assign byte_o = (32'(byte_idx_i) < gopigo_pkg::FRAME_BYTES) ? frame_q[byte_idx_i] : '0;

endmodule

`default_nettype wire

// File: src/gopigo_pkg.sv
//##########################################################
// gopigo package
// payload types, channel codes, spi message constants and
// timing constants shared by the command bridge
//##########################################################
`default_nettype none

package gopigo_pkg;

  // payload types
  typedef logic [7:0]        byte_t;  // one spi byte
  typedef logic signed [7:0] pwm_t;   // two's complement, -100 to 100
  typedef logic [15:0]       dps_t;   // degrees per second, msb goes first
  typedef logic [23:0]       rgb_t;   // red [23:16], green [15:8], blue [7:0]

  // command channels, listed in scan order
  typedef enum logic [2:0] {
    CH_PWM_LEFT  = 3'd0,
    CH_PWM_RGHT  = 3'd1,
    CH_DPS_LIMIT = 3'd2,  // one limit shared by both motors
    CH_EYE_LEFT  = 3'd3,
    CH_EYE_RGHT  = 3'd4
  } cmd_chan_e;

  localparam int NUM_CHAN = 5;

  // every frame opens with the slave address
  localparam byte_t SPI_ADDR = 8'h08;

  // message types
  localparam byte_t MSG_SET_MOTOR_PWM    = 8'h0A;
  localparam byte_t MSG_SET_MOTOR_LIMITS = 8'h0F;
  localparam byte_t MSG_SET_LED          = 8'h06;

  // target codes
  localparam byte_t TGT_MOTOR_LEFT = 8'h01;
  localparam byte_t TGT_MOTOR_RGHT = 8'h02;
  localparam byte_t TGT_MOTOR_BOTH = 8'h03;  // left | right
  localparam byte_t TGT_EYE_LEFT   = 8'h02;
  localparam byte_t TGT_EYE_RGHT   = 8'h01;  // eye codes are swapped vs motors

  // frame geometry
  localparam int FRAME_BYTES = 6;            // led and limit frames
  typedef logic [2:0] frame_idx_t;           // byte index in a frame

  // timing, in clock cycles
  localparam int GUARD_CYCLES = 500;         // select held before and after bytes
  localparam int SPI_CLK_DIV  = 12;          // clock enable period, 12 MHz -> 1 MHz

endpackage

`default_nettype wire

// File: src/gopigo_spi_ctrl.sv
//##########################################################
// gopigo spi control
// sends changed motor and led commands to the robot board
// as spi frames: scan decode, frame build, byte sequencer
//##########################################################
`timescale 1ns/1ps
`default_nettype none

module gopigo_spi_ctrl (
  input  wire                  rst,          // system clock
  input  wire                  clk,          // async reset, active high
  input  wire                  busy_spi_i,   // spi master busy
  input  wire gopigo_pkg::pwm_t pwm_left_i,  // left motor pwm
  input  wire gopigo_pkg::pwm_t pwm_rght_i,  // right motor pwm
  input  wire gopigo_pkg::dps_t dps_limit_i, // speed limit, both motors
  input  wire gopigo_pkg::rgb_t eye_left_i,  // left eye colour
  input  wire gopigo_pkg::rgb_t eye_rght_i,  // right eye colour
  output logic                 spi_ss_n_o,
  output logic                 spi_send_o,
  output logic                 ena_2clk_o,
  output gopigo_pkg::byte_t    data_spi_o
);

  logic                   scan_en;
  logic                   load;
  logic                   cmd_valid;
  gopigo_pkg::cmd_chan_e  cmd_sel;
  gopigo_pkg::frame_idx_t last_idx;
  gopigo_pkg::frame_idx_t byte_idx;

  // finds the next changed channel
  cmd_scan_decode u_decode (
    .rst         (rst),
    .clk         (clk),
    .scan_en_i   (scan_en),
    .load_i      (load),
    .pwm_left_i  (pwm_left_i),
    .pwm_rght_i  (pwm_rght_i),
    .dps_limit_i (dps_limit_i),
    .eye_left_i  (eye_left_i),
    .eye_rght_i  (eye_rght_i),
    .cmd_valid_o (cmd_valid),
    .cmd_sel_o   (cmd_sel)
  );

  // frame bytes go straight out as spi data
  frame_build_exec u_exec (
    .rst         (rst),
    .clk         (clk),
    .load_i      (load),
    .cmd_sel_i   (cmd_sel),
    .pwm_left_i  (pwm_left_i),
    .pwm_rght_i  (pwm_rght_i),
    .dps_limit_i (dps_limit_i),
    .eye_left_i  (eye_left_i),
    .eye_rght_i  (eye_rght_i),
    .byte_idx_i  (byte_idx),
    .last_idx_o  (last_idx),
    .byte_o      (data_spi_o)
  );

  spi_seq_result u_result (
    .rst         (rst),
    .clk         (clk),
    .cmd_valid_i (cmd_valid),
    .busy_spi_i  (busy_spi_i),
    .last_idx_i  (last_idx),
    .scan_en_o   (scan_en),
    .load_o      (load),
    .byte_idx_o  (byte_idx),
    .spi_ss_n_o  (spi_ss_n_o),
    .spi_send_o  (spi_send_o),
    .ena_2clk_o  (ena_2clk_o)
  );

endmodule

`default_nettype wire

// File: src/shadow_cmd_reg.sv
//##########################################################
// shadow command register
// last value sent on one channel, plus a change flag
//##########################################################
`timescale 1ns/1ps
`default_nettype none

module shadow_cmd_reg #(
  parameter type payload_t = logic [7:0]
) (
  input  wire           rst,        // clock
  input  wire           clk,        // async reset, active high
  input  wire           load_i,     // capture the live value
  input  wire payload_t value_i,    // live command input
  output logic          changed_o   // live value differs from last sent
);

  payload_t shadow_q;  // value at the last load

  // cleared to zero so a zero input after reset is seen as already sent
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      shadow_q <= '0;
    end else if (load_i) begin
      shadow_q <= value_i;
    end
  end

  // compare on the full payload width
  assign changed_o = (value_i != shadow_q);

endmodule

`default_nettype wire

// File: src/spi_seq_result.sv
//##########################################################
// spi sequencer result
// drives select, send pulses and the spi clock enable for
// one frame, pacing bytes on the busy level of the master
//##########################################################
`timescale 1ns/1ps
`default_nettype none

module spi_seq_result (
  input  wire                        rst,          // clock
  input  wire                        clk,          // async reset, active high
  input  wire                        cmd_valid_i,  // scanned channel has changed
  input  wire                        busy_spi_i,   // master shifting a byte
  input  wire gopigo_pkg::frame_idx_t last_idx_i,  // final byte of the frame
  output logic                       scan_en_o,    // decode may scan
  output logic                       load_o,       // capture pulse
  output gopigo_pkg::frame_idx_t     byte_idx_o,   // byte being sent
  output logic                       spi_ss_n_o,   // slave select, active low
  output logic                       spi_send_o,   // start one byte
  output logic                       ena_2clk_o    // twice the sck rate
);

  typedef enum logic [2:0] {
    ST_IDLE,       // scanning for changes
    ST_LOAD,       // shadow and frame capture
    ST_GUARD_IN,   // select low before the first byte
    ST_SEND,       // send pulse
    ST_WAIT_BUSY,  // wait for the master to take the byte
    ST_WAIT_IDLE,  // wait for the byte to finish
    ST_GUARD_OUT,  // select low after the last byte
    ST_FINISH      // select high, one cycle
  } seq_state_e;

  typedef logic [$clog2(gopigo_pkg::GUARD_CYCLES)-1:0] guard_cnt_t;
  typedef logic [$clog2(gopigo_pkg::SPI_CLK_DIV)-1:0]  div_cnt_t;

  seq_state_e             state_q, state_d;
  guard_cnt_t             guard_q;
  div_cnt_t               div_q;
  gopigo_pkg::frame_idx_t byte_q;
  logic                   guard_run;  // in either guard state
  logic                   guard_done; // last guard cycle
  logic                   div_end;
  logic                   byte_inc;
  logic                   ss_active;

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d  = state_q;
    byte_inc = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (cmd_valid_i) state_d = ST_LOAD;
      end
      ST_LOAD: state_d = ST_GUARD_IN;
      ST_GUARD_IN: begin
        if (guard_done) state_d = ST_SEND;
      end
      ST_SEND: state_d = ST_WAIT_BUSY;
      ST_WAIT_BUSY: begin
        if (busy_spi_i) state_d = ST_WAIT_IDLE;   // no timeout, master paces us
      end
      ST_WAIT_IDLE: begin
        if (!busy_spi_i) begin
          if (byte_q == last_idx_i) begin
            state_d = ST_GUARD_OUT;
          end else begin
            byte_inc = 1'b1;
            state_d  = ST_SEND;
          end
        end
      end
      ST_GUARD_OUT: begin
        if (guard_done) state_d = ST_FINISH;
      end
      ST_FINISH: state_d = ST_IDLE;
      default:   state_d = ST_IDLE;
    endcase
  end

  // guard timer, restarts for each guard state
  assign guard_run  = (state_q == ST_GUARD_IN) || (state_q == ST_GUARD_OUT);
  assign guard_done = guard_run && (guard_q == guard_cnt_t'(gopigo_pkg::GUARD_CYCLES - 1));

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      guard_q <= '0;
    end else if (!guard_run || guard_done) begin
      guard_q <= '0;
    end else begin
      guard_q <= guard_q + 1'b1;
    end
  end

  // byte counter, back to the address byte while idle
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      byte_q <= '0;
    end else if (state_q == ST_IDLE) begin
      byte_q <= '0;
    end else if (byte_inc) begin
      byte_q <= byte_q + 1'b1;
    end
  end

  assign ss_active = state_q inside {ST_GUARD_IN, ST_SEND, ST_WAIT_BUSY,
                                     ST_WAIT_IDLE, ST_GUARD_OUT};

  // clock enable divider, held at zero while select is off
  assign div_end = (div_q == div_cnt_t'(gopigo_pkg::SPI_CLK_DIV - 1));

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      div_q <= '0;
    end else if (!ss_active || div_end) begin
      div_q <= '0;
    end else begin
      div_q <= div_q + 1'b1;
    end
  end

  assign scan_en_o  = (state_q == ST_IDLE);
  assign load_o     = (state_q == ST_LOAD);
  assign byte_idx_o = byte_q;
  assign spi_ss_n_o = !ss_active;
  assign spi_send_o = (state_q == ST_SEND);
  assign ena_2clk_o = ss_active && div_end;  // divider may sit at the end in finish

endmodule

`default_nettype wire

// File: verification/gopigo_spi_chk.sv
//##########################################################
// gopigo spi checker
// concurrent assertions on the spi pins of the top level
//##########################################################
`timescale 1ns/1ps
`default_nettype none

module gopigo_spi_chk (
  input wire rst,         // clock
  input wire clk,         // async reset, active high
  input wire spi_ss_n_o,
  input wire spi_send_o,
  input wire ena_2clk_o
);

  // a send pulse only happens inside an active select
  a_send_in_ss: assert property (@(posedge rst) disable iff (clk)
    spi_send_o |-> !spi_ss_n_o)
    else $error("send pulse while slave select is inactive");

  a_send_one_cycle: assert property (@(posedge rst) disable iff (clk)
    spi_send_o |=> !spi_send_o)
    else $error("send pulse longer than one cycle");

  // divider held while select is off
  a_ena_idle: assert property (@(posedge rst) disable iff (clk)
    spi_ss_n_o |-> !ena_2clk_o)
    else $error("clock enable pulse while slave select is inactive");

  a_reset_quiet: assert property (@(posedge rst)
    clk |-> (spi_ss_n_o && !spi_send_o))
    else $error("spi pins active during reset");

endmodule

bind gopigo_spi_ctrl gopigo_spi_chk u_chk (
  .rst        (rst),
  .clk        (clk),
  .spi_ss_n_o (spi_ss_n_o),
  .spi_send_o (spi_send_o),
  .ena_2clk_o (ena_2clk_o)
);

`default_nettype wire

// File: verification/tb_gopigo_spi_ctrl.sv
//##########################################################
// gopigo spi control testbench
// table of command rows, spi master model with busy jitter,
// frame prediction and byte compare
//##########################################################
`timescale 1ns/1ps
`default_nettype none

module tb_gopigo_spi_ctrl;

  localparam int NROWS = 11;
  localparam int LIMIT = NROWS * 2 * (2 * gopigo_pkg::GUARD_CYCLES + 6 * 40);

  logic rst = 1'b0;  // clock
  logic clk;         // reset
  logic busy_spi;
  gopigo_pkg::pwm_t pl, pr;
  gopigo_pkg::dps_t dps;
  gopigo_pkg::rgb_t el, er;
  logic spi_ss_n, spi_send, ena_2clk;
  gopigo_pkg::byte_t data_spi;

  // stimulus table, a mid row is applied during the previous row's frame
  gopigo_pkg::pwm_t t_pl [NROWS] = '{8'd0, 8'd25, 8'd25, 8'd25, 8'd25, 8'd25, 8'd25,
                                     8'hF9, 8'hF9, 8'hF9, 8'hF9};
  gopigo_pkg::pwm_t t_pr [NROWS] = '{8'd0, 8'd0, 8'h9C, 8'h9C, 8'h9C, 8'h9C, 8'h9C,
                                     8'h9C, 8'h9C, 8'd50, 8'hFF};
  gopigo_pkg::dps_t t_dps [NROWS] = '{16'h0, 16'h0, 16'h0, 16'h0, 16'h1234, 16'h1234,
                                      16'h1234, 16'h0300, 16'h0300, 16'h0300, 16'h0300};
  gopigo_pkg::rgb_t t_el [NROWS] = '{24'h0, 24'h0, 24'h0, 24'h0, 24'h0, 24'hFF8000,
                                     24'hFF8000, 24'hFF8000, 24'hFF8000, 24'hFF8000,
                                     24'h010203};
  gopigo_pkg::rgb_t t_er [NROWS] = '{24'h0, 24'h0, 24'h0, 24'h0, 24'h0, 24'h0,
                                     24'h0040C0, 24'h112233, 24'h112233, 24'h112233,
                                     24'h112233};
  logic t_mid [NROWS] = '{0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 1};

  logic [23:0] shadow [gopigo_pkg::NUM_CHAN];  // model of last sent values
  int          ptr;                            // channel where the scan rests
  logic [47:0] exp_frame [$];                  // left aligned, byte 0 on top
  int          exp_len [$];
  logic [47:0] rx_frame [$];
  int          rx_len [$];
  logic [31:0] seed = 32'h8902;
  int          cycles = 0;
  int          errors = 0;
  int          checks = 0;

  gopigo_spi_ctrl dut_i (
    .rst(rst), .clk(clk), .busy_spi_i(busy_spi),
    .pwm_left_i(pl), .pwm_rght_i(pr), .dps_limit_i(dps),
    .eye_left_i(el), .eye_rght_i(er),
    .spi_ss_n_o(spi_ss_n), .spi_send_o(spi_send), .ena_2clk_o(ena_2clk),
    .data_spi_o(data_spi));

  always #5 rst = ~rst;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [23:0] row_value(input int r, input int ch);
    case (ch)
      0: return {16'h0, t_pl[r]};
      1: return {16'h0, t_pr[r]};
      2: return {8'h0, t_dps[r]};
      3: return t_el[r];
      default: return t_er[r];
    endcase
  endfunction

  // frame layout per channel
  function automatic logic [47:0] encode(input int ch, input logic [23:0] v);
    case (ch)
      0: return {gopigo_pkg::SPI_ADDR, gopigo_pkg::MSG_SET_MOTOR_PWM,
                 gopigo_pkg::TGT_MOTOR_LEFT, v[7:0], 16'h0};
      1: return {gopigo_pkg::SPI_ADDR, gopigo_pkg::MSG_SET_MOTOR_PWM,
                 gopigo_pkg::TGT_MOTOR_RGHT, v[7:0], 16'h0};
      2: return {gopigo_pkg::SPI_ADDR, gopigo_pkg::MSG_SET_MOTOR_LIMITS,
                 gopigo_pkg::TGT_MOTOR_BOTH, 8'h00, v[15:0]};
      3: return {gopigo_pkg::SPI_ADDR, gopigo_pkg::MSG_SET_LED, gopigo_pkg::TGT_EYE_LEFT, v};
      default: return {gopigo_pkg::SPI_ADDR, gopigo_pkg::MSG_SET_LED,
                       gopigo_pkg::TGT_EYE_RGHT, v};
    endcase
  endfunction

  // changed channels in scan order, starting where the scan rests
  task automatic predict_row(input int r);
    int ch;
    for (int k = 0; k < gopigo_pkg::NUM_CHAN; k++) begin
      ch = (ptr + k) % gopigo_pkg::NUM_CHAN;
      if (row_value(r, ch) != shadow[ch]) begin
        exp_frame.push_back(encode(ch, row_value(r, ch)));
        exp_len.push_back(ch < 2 ? 4 : 6);
        shadow[ch] = row_value(r, ch);
        ptr = ch;
      end
    end
  endtask

  task automatic apply_row(input int r);
    pl  <= t_pl[r];
    pr  <= t_pr[r];
    dps <= t_dps[r];
    el  <= t_el[r];
    er  <= t_er[r];
  endtask

  // select has to stay high while no change is pending
  task automatic watch_quiet(input int n, output logic quiet);
    quiet = 1'b1;
    repeat (n) begin
      @(posedge rst);
      if (spi_ss_n !== 1'b1) quiet = 1'b0;
    end
  endtask

  // spi master: busy two cycles after send, held 8 plus jitter
  always begin
    int hold;
    @(posedge rst);
    if (spi_send) begin
      seed = lcg_next(seed);
      hold = 8 + int'(seed[17:16]);
      repeat (2) @(posedge rst);
      busy_spi <= 1'b1;
      repeat (hold) @(posedge rst);
      busy_spi <= 1'b0;
    end
  end

  // frame capture and clock enable spacing
  logic [47:0] cur;
  int          cur_n = 0;
  logic        ss_q = 1'b1;
  int          gap = 0;
  logic        gap_seen = 1'b0;
  always @(posedge rst) begin
    if (spi_send) begin
      cur   = {cur[39:0], data_spi};
      cur_n = cur_n + 1;
    end
    gap = gap + 1;
    if (ena_2clk) begin
      if (gap_seen) begin
        a_gap: assert (gap == gopigo_pkg::SPI_CLK_DIV)
          else begin
            $display("Fail %0t ena_2clk_o gap exp %0d got %0d", $time,
                     gopigo_pkg::SPI_CLK_DIV, gap);
            errors++;
          end
      end
      gap      = 0;
      gap_seen = 1'b1;
    end
    if (!ss_q && spi_ss_n) begin  // select rising ends a frame
      rx_frame.push_back(cur << (8 * (6 - cur_n)));
      rx_len.push_back(cur_n);
      cur_n = 0;
    end
    if (spi_ss_n) gap_seen = 1'b0;
    ss_q = spi_ss_n;
  end

  always @(posedge rst) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("timeout: frames did not arrive within the cycle limit");
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic compare_frames(input int r, input logic quiet);
    int row_err;
    row_err = errors;
    checks++;
    a_quiet: assert (quiet)
      else begin
        $display("Fail %0t spi_ss_n_o exp 1 got 0 with no change pending", $time);
        errors++;
      end
    checks++;
    a_count: assert (rx_frame.size() == exp_frame.size())
      else begin
        $display("Fail %0t frame_count exp %0d got %0d", $time, exp_frame.size(),
                 rx_frame.size());
        errors++;
      end
    for (int f = 0; f < exp_frame.size() && f < rx_frame.size(); f++) begin
      checks++;
      a_len: assert (rx_len[f] == exp_len[f])
        else begin
          $display("Fail %0t byte_count exp %0d got %0d", $time, exp_len[f], rx_len[f]);
          errors++;
        end
      for (int b = 0; b < exp_len[f]; b++) begin
        checks++;
        a_byte: assert (rx_frame[f][47-8*b -: 8] == exp_frame[f][47-8*b -: 8])
          else begin
            $display("Fail %0t data_spi_o exp %h got %h", $time,
                     exp_frame[f][47-8*b -: 8], rx_frame[f][47-8*b -: 8]);
            errors++;
          end
      end
    end
    $display("row %0d: %0d frames, %s", r, rx_frame.size(),
             (errors == row_err) ? "ok" : "mismatch");
    exp_frame.delete();
    exp_len.delete();
    rx_frame.delete();
    rx_len.delete();
  endtask

  initial begin
    logic quiet;
    clk      = 1'b1;
    busy_spi = 1'b0;
    pl       = '0;
    pr       = '0;
    dps      = '0;
    el       = '0;
    er       = '0;
    foreach (shadow[i]) shadow[i] = '0;
    ptr = 0;
    repeat (3) @(posedge rst);
    clk <= 1'b0;
    for (int r = 0; r < NROWS; r++) begin
      if (!t_mid[r]) begin
        @(posedge rst);
        apply_row(r);
        predict_row(r);
        if (r + 1 < NROWS && t_mid[r + 1]) begin
          @(posedge rst);
          while (!spi_send) @(posedge rst);
          apply_row(r + 1);  // lands after the frame was latched
          predict_row(r + 1);
        end
        while (rx_frame.size() < exp_frame.size()) @(posedge rst);
        watch_quiet(200, quiet);  // no extra frame may start
        compare_frames(r, quiet);
      end
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
